/* compile.f */
hdl/udp_cmd_pkg.sv
hdl/word_fifo.sv
hdl/cmd_header_decode.sv
hdl/burst_counter.sv
hdl/udp_cmd_ctrl.sv
hdl/udp_axi_cmd_top.sv
verif/bus_mem_model.sv
verif/tb_udp_axi_cmd.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_udp_axi_cmd \
  -f compile.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "^TEST PASSED$" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }

/* verif/tb_udp_axi_cmd.sv */
`timescale 1ns/1ps

module tb_udp_axi_cmd;

  localparam int                 N_PAIRS = 4;
  localparam udp_cmd_pkg::word_t SEED    = 32'h18d1f831;

  logic                  gmii_rx_clk;
  logic                  rst_n;
  logic                  rec_en;
  logic                  rec_pkt_done;
  udp_cmd_pkg::word_t    datain;
  logic                  tx_req;
  logic                  tx_start_en;
  udp_cmd_pkg::word_t    udp_tx_data;
  udp_cmd_pkg::bus_req_t wr_req;
  udp_cmd_pkg::bus_req_t rd_req;
  udp_cmd_pkg::word_t    wr_data;
  udp_cmd_pkg::word_t    rd_data;
  udp_cmd_pkg::strb_t    wr_strb;
  logic                  wr_addr_valid;
  logic                  wr_addr_ready;
  logic                  wr_data_valid;
  logic                  wr_data_ready;
  logic                  wr_data_last;
  logic                  rd_addr_valid;
  logic                  rd_addr_ready;
  logic                  rd_data_valid;
  logic                  rd_data_ready;
  logic                  rd_data_last;
  logic [7:0]            rand_bits;

  udp_cmd_pkg::word_t exp_mem [int];  // Expected contents by word address
  udp_cmd_pkg::word_t payload [$];
  udp_cmd_pkg::word_t rnd_state;
  udp_cmd_pkg::len_t  cur_len;
  udp_cmd_pkg::addr_t cur_addr;
  udp_cmd_pkg::len_t  pair_len  [N_PAIRS];
  udp_cmd_pkg::addr_t pair_addr [N_PAIRS];
  udp_cmd_pkg::word_t pair_seed [N_PAIRS];
  logic pkt_wr = 1'b0;
  logic pkt_rd = 1'b0;
  logic drop_window = 1'b0;
  int   mismatch_cnt = 0;
  int   violation_cnt = 0;
  int   cycles = 0;
  int   cycle_limit = 2000;
  int   wr_beats = 0;
  int   rd_beats = 0;
  int   tx_starts = 0;
  int   reads_sent = 0;

  udp_axi_cmd_top UUT (.*);
  bus_mem_model u_mem (.*);

  always #4 gmii_rx_clk = ~gmii_rx_clk;

  function automatic udp_cmd_pkg::word_t xorshift32(udp_cmd_pkg::word_t x);
    udp_cmd_pkg::word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic udp_cmd_pkg::word_t expected_word(udp_cmd_pkg::addr_t a);
    if (exp_mem.exists(int'(a >> 2))) begin
      return exp_mem[int'(a >> 2)];
    end
    return ~udp_cmd_pkg::word_t'(a >> 2);
  endfunction

  task automatic report_mismatch(string name, udp_cmd_pkg::word_t got,
                                 udp_cmd_pkg::word_t exp);
    mismatch_cnt++;
    $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
  endtask

  task automatic report_violation(string what);
    violation_cnt++;
    $display("Error at %0t ns: %s", $time, what);
  endtask

  task automatic check_request(string name, udp_cmd_pkg::bus_req_t req);
    a_req_addr: assert (req.addr == cur_addr)
      else report_mismatch({name, ".addr"}, 32'(req.addr), 32'(cur_addr));
    a_req_len: assert (req.len == cur_len)
      else report_mismatch({name, ".len"}, 32'(req.len), 32'(cur_len));
  endtask

  task automatic fill_payload(udp_cmd_pkg::word_t seed, int n);
    udp_cmd_pkg::word_t w;
    w = seed;
    payload.delete();
    repeat (n) begin
      w = xorshift32(w);
      payload.push_back(w);
    end
  endtask

  task automatic send_packet(udp_cmd_pkg::opcode_t op, udp_cmd_pkg::len_t len,
                             udp_cmd_pkg::addr_t addr);
    int i;
    @(posedge gmii_rx_clk);
    #1;
    rec_en = 1'b1;
    datain = {op, 20'd0, len};
    @(posedge gmii_rx_clk);
    #1;
    datain = {4'd0, addr};
    for (i = 0; i < payload.size(); i++) begin
      @(posedge gmii_rx_clk);
      #1;
      datain = payload[i];
    end
    @(posedge gmii_rx_clk);
    #1;
    rec_en       = 1'b0;
    rec_pkt_done = 1'b1;
    @(posedge gmii_rx_clk);
    #1;
    rec_pkt_done = 1'b0;
  endtask

  task automatic write_burst(udp_cmd_pkg::len_t len, udp_cmd_pkg::addr_t addr,
                             udp_cmd_pkg::word_t seed);
    int i;
    fill_payload(seed, int'(len) + 1);
    cur_len  = len;
    cur_addr = addr;
    wr_beats = 0;
    pkt_wr   = 1'b1;
    send_packet(udp_cmd_pkg::OP_WRITE, len, addr);
    pkt_wr = 1'b0;
    @(posedge gmii_rx_clk);
    while (!(wr_data_valid && wr_data_ready && wr_data_last)) begin
      @(posedge gmii_rx_clk);
    end
    #1;
    a_wr_count: assert (wr_beats == int'(len) + 1)
      else report_violation("write burst moved a wrong number of beats");
    for (i = 0; i <= int'(len); i++) begin
      exp_mem[int'((addr + udp_cmd_pkg::addr_t'(4 * i)) >> 2)] = payload[i];
    end
  endtask

  task automatic read_burst(udp_cmd_pkg::len_t len, udp_cmd_pkg::addr_t addr);
    int i;
    udp_cmd_pkg::word_t exp;
    payload.delete();
    cur_len  = len;
    cur_addr = addr;
    rd_beats = 0;
    reads_sent++;
    pkt_rd = 1'b1;
    send_packet(udp_cmd_pkg::OP_READ, len, addr);
    pkt_rd = 1'b0;
    @(posedge gmii_rx_clk);
    while (!tx_start_en) begin
      @(posedge gmii_rx_clk);
    end
    #1;
    a_rd_count: assert (rd_beats == int'(len) + 1)
      else report_violation("read burst moved a wrong number of beats");
    a_start_once: assert (tx_starts == reads_sent)
      else report_violation("tx_start_en count differs from read packets");
    for (i = 0; i <= int'(len); i++) begin
      tx_req = 1'b1;
      @(posedge gmii_rx_clk);
      #1;
      tx_req = 1'b0;
      exp = expected_word(addr + udp_cmd_pkg::addr_t'(4 * i));
      a_reply: assert (udp_tx_data == exp)
        else report_mismatch("udp_tx_data", udp_tx_data, exp);
      if (i == 0 && len != 0) begin  // Write packet in mid reply must be ignored
        fill_payload(SEED ^ 32'h0000_a5a5, 3);
        send_packet(udp_cmd_pkg::OP_WRITE, 8'd2, addr);
      end
      repeat (i % 3) begin  // Uneven tx_req spacing
        @(posedge gmii_rx_clk);
        #1;
      end
    end
    a_reply_end: assert (UUT.u_ctrl.state == udp_cmd_pkg::IDLE)
      else report_violation("reply did not end after len+1 words");
  endtask

  task automatic drop_packet(udp_cmd_pkg::opcode_t op, udp_cmd_pkg::len_t len,
                             udp_cmd_pkg::addr_t addr, int n_words);
    fill_payload(SEED ^ 32'h0000_5a5a, n_words);
    drop_window = 1'b1;
    send_packet(op, len, addr);
    repeat (3) @(posedge gmii_rx_clk);
    #1;
    drop_window = 1'b0;
  endtask

  a_reset_quiet: assert property (@(posedge gmii_rx_clk)
    !rst_n |=> !wr_addr_valid && !wr_data_valid && !rd_addr_valid && !rd_data_ready &&
               !tx_start_en)
    else report_violation("bus or start output high after reset");

  a_wr_req_timing: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
    rec_pkt_done && pkt_wr |=> $rose(wr_addr_valid))
    else report_violation("wr_addr_valid did not rise one cycle after rec_pkt_done");

  a_rd_req_timing: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
    rec_pkt_done && pkt_rd |=> $rose(rd_addr_valid))
    else report_violation("rd_addr_valid did not rise one cycle after rec_pkt_done");

  a_req_cause: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
    $rose(wr_addr_valid || rd_addr_valid) |-> $past(rec_pkt_done))
    else report_violation("address request rose without rec_pkt_done before it");

  a_wr_addr_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
    wr_addr_valid && !wr_addr_ready |=> wr_addr_valid && $stable(wr_req))
    else report_violation("wr_req changed or dropped before wr_addr_ready");

  a_wr_data_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
    wr_data_valid && !wr_data_ready |=>
      wr_data_valid && $stable(wr_data) && $stable(wr_data_last))
    else report_violation("write beat changed or dropped before wr_data_ready");

  a_rd_addr_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
    rd_addr_valid && !rd_addr_ready |=> rd_addr_valid && $stable(rd_req))
    else report_violation("rd_req changed or dropped before rd_addr_ready");

  a_full_strobe: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
    wr_data_valid |-> wr_strb == 4'hf)
    else report_violation("write beat without all byte strobes");

  a_drop_quiet: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
    drop_window |-> !wr_addr_valid && !rd_addr_valid && !tx_start_en)
    else report_violation("dropped packet caused bus or reply activity");

  always @(posedge gmii_rx_clk) begin
    if (rst_n) begin
      if (wr_addr_valid && wr_addr_ready) begin
        check_request("wr_req", wr_req);
      end
      if (rd_addr_valid && rd_addr_ready) begin
        check_request("rd_req", rd_req);
      end
      if (wr_data_valid && wr_data_ready) begin
        a_wr_last: assert (wr_data_last == (wr_beats == int'(cur_len)))
          else report_violation("wr_data_last does not mark the final beat only");
        if (wr_beats < payload.size()) begin
          a_wr_data: assert (wr_data == payload[wr_beats])
            else report_mismatch("wr_data", wr_data, payload[wr_beats]);
        end
        wr_beats++;
      end
      if (rd_data_valid && rd_data_ready) begin
        rd_beats++;
      end
      if (tx_start_en) begin
        tx_starts++;
      end
    end
  end

  always @(posedge gmii_rx_clk) begin
    #1;
    rnd_state = xorshift32(rnd_state);
    rand_bits = rnd_state[7:0];  // Ready and valid stalls of the memory
  end

  always @(posedge gmii_rx_clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Errors: %0d mismatches, %0d protocol errors", mismatch_cnt, violation_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    int i;
    int total;
    udp_cmd_pkg::len_t  unw_len;
    udp_cmd_pkg::addr_t unw_addr;
    gmii_rx_clk  = 1'b0;
    rst_n        = 1'b0;
    rec_en       = 1'b0;
    rec_pkt_done = 1'b0;
    datain       = '0;
    tx_req       = 1'b0;
    rand_bits    = '0;
    rnd_state    = SEED;
    total        = 0;
    for (i = 0; i < N_PAIRS; i++) begin
      rnd_state    = xorshift32(rnd_state);
      pair_addr[i] = {14'd0, rnd_state[13:2], 2'b00};
      pair_len[i]  = (i == 0) ? 8'd0 : (i == 1) ? 8'd255 : {2'b00, rnd_state[21:16]};
      pair_seed[i] = xorshift32(rnd_state ^ 32'h0000_ffff);
      total += 2 * (int'(pair_len[i]) + 1);
    end
    rnd_state = xorshift32(rnd_state);
    unw_len   = {3'b000, rnd_state[20:16]};
    unw_addr  = {4'h8, 8'd0, rnd_state[15:2], 2'b00};  // Far above any written word
    total += int'(unw_len) + 1 + 4 + 5 + 6;
    cycle_limit = 20 * total + 2000;

    repeat (5) @(posedge gmii_rx_clk);
    #1;
    rst_n = 1'b1;

    for (i = 0; i < N_PAIRS; i++) begin
      write_burst(pair_len[i], pair_addr[i], pair_seed[i]);
      read_burst(pair_len[i], pair_addr[i]);
    end
    read_burst(unw_len, unw_addr);
    drop_packet(4'h7, 8'd3, pair_addr[2], 4);
    drop_packet(udp_cmd_pkg::OP_WRITE, 8'd5, pair_addr[0], 5);  // One word short
    read_burst(8'd5, pair_addr[0]);

    repeat (5) @(posedge gmii_rx_clk);
    a_start_total: assert (tx_starts == reads_sent)
      else report_violation("tx_start_en count differs from read packets");
    $display("Errors: %0d mismatches, %0d protocol errors", mismatch_cnt, violation_cnt);
    if (mismatch_cnt == 0 && violation_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verif/bus_mem_model.sv */
`timescale 1ns/1ps

module bus_mem_model (
  input  logic                  gmii_rx_clk,
  input  logic                  rst_n,
  input  logic [7:0]            rand_bits,
  input  udp_cmd_pkg::bus_req_t wr_req,
  input  logic                  wr_addr_valid,
  output logic                  wr_addr_ready,
  input  udp_cmd_pkg::word_t    wr_data,
  input  udp_cmd_pkg::strb_t    wr_strb,
  input  logic                  wr_data_valid,
  output logic                  wr_data_ready,
  input  udp_cmd_pkg::bus_req_t rd_req,
  input  logic                  rd_addr_valid,
  output logic                  rd_addr_ready,
  output udp_cmd_pkg::word_t    rd_data,
  output logic                  rd_data_last,
  input  logic                  rd_data_ready,
  output logic                  rd_data_valid
);

  udp_cmd_pkg::word_t mem [int];  // Keyed by word address
  udp_cmd_pkg::addr_t w_addr;
  udp_cmd_pkg::addr_t r_addr;
  udp_cmd_pkg::len_t  r_len;
  udp_cmd_pkg::len_t  r_beat;
  logic               r_active;
  logic               run;
  logic               hold;
  logic [7:0]         bits;

  function automatic udp_cmd_pkg::word_t read_word(udp_cmd_pkg::addr_t a);
    int idx;
    idx = int'(a >> 2);
    if (mem.exists(idx)) begin
      return mem[idx];
    end
    return ~udp_cmd_pkg::word_t'(a >> 2);  // Untouched word reads as inverted word address
  endfunction

  task automatic store_word(udp_cmd_pkg::addr_t a, udp_cmd_pkg::word_t d,
                            udp_cmd_pkg::strb_t s);
    udp_cmd_pkg::word_t w;
    int b;
    w = read_word(a);
    for (b = 0; b < 4; b++) begin
      if (s[b]) begin
        w[8*b +: 8] = d[8*b +: 8];
      end
    end
    mem[int'(a >> 2)] = w;
  endtask

  initial begin
    wr_addr_ready = 1'b0;
    wr_data_ready = 1'b0;
    rd_addr_ready = 1'b0;
    rd_data_valid = 1'b0;
    rd_data_last  = 1'b0;
    rd_data       = '0;
    r_active      = 1'b0;
  end

  always @(posedge gmii_rx_clk) begin
    run  = rst_n;
    bits = rand_bits;
    hold = rd_data_valid && !rd_data_ready;
    if (!run) begin
      r_active = 1'b0;
    end else begin
      if (wr_addr_valid && wr_addr_ready) begin
        w_addr = wr_req.addr;
      end
      if (wr_data_valid && wr_data_ready) begin
        store_word(w_addr, wr_data, wr_strb);
        w_addr = w_addr + udp_cmd_pkg::addr_t'(udp_cmd_pkg::ADDR_STEP);
      end
      if (rd_data_valid && rd_data_ready) begin
        r_active = !rd_data_last;
        r_addr   = r_addr + udp_cmd_pkg::addr_t'(udp_cmd_pkg::ADDR_STEP);
        r_beat   = r_beat + 8'd1;
      end
      if (rd_addr_valid && rd_addr_ready && !r_active) begin
        r_active = 1'b1;
        r_addr   = rd_req.addr;
        r_len    = rd_req.len;
        r_beat   = '0;
      end
    end
    #1;
    wr_addr_ready = run && (bits[1:0] != 2'b00);  // Ready about three cycles in four
    wr_data_ready = run && (bits[3:2] != 2'b00);
    rd_addr_ready = run && (bits[5:4] != 2'b00);
    if (!hold || !run) begin
      rd_data_valid = run && r_active && (bits[7:6] != 2'b00);
      rd_data       = read_word(r_addr);
      rd_data_last  = (r_beat == r_len);
    end
  end

endmodule

/* hdl/udp_axi_cmd_top.sv */
`timescale 1ns/1ps

module udp_axi_cmd_top (
  input  logic                  gmii_rx_clk,
  input  logic                  rst_n,
  input  logic                  rec_en,
  input  logic                  rec_pkt_done,
  input  udp_cmd_pkg::word_t    datain,
  input  logic                  tx_req,
  output logic                  tx_start_en,
  output udp_cmd_pkg::word_t    udp_tx_data,
  output udp_cmd_pkg::bus_req_t wr_req,
  output logic                  wr_addr_valid,
  input  logic                  wr_addr_ready,
  output udp_cmd_pkg::word_t    wr_data,
  output udp_cmd_pkg::strb_t    wr_strb,
  output logic                  wr_data_valid,
  input  logic                  wr_data_ready,
  output logic                  wr_data_last,
  output udp_cmd_pkg::bus_req_t rd_req,
  output logic                  rd_addr_valid,
  input  logic                  rd_addr_ready,
  input  udp_cmd_pkg::word_t    rd_data,
  input  logic                  rd_data_last,
  output logic                  rd_data_ready,
  input  logic                  rd_data_valid
);

  udp_cmd_pkg::cmd_t cmd;

  logic wdata_push;
  logic decode_enable;
  logic cnt_load;
  logic cnt_beat;
  logic cnt_last;
  logic cnt_done;
  logic wf_pop;
  logic rf_push;
  logic rf_pop;
  logic fifo_flush;

  assign wr_req       = '{addr: cmd.addr, len: cmd.len};
  assign rd_req       = '{addr: cmd.addr, len: cmd.len};
  assign wr_strb      = '1;        // Full word writes only
  assign wr_data_last = cnt_last;

  cmd_header_decode u_decode (
    .gmii_rx_clk  (gmii_rx_clk),
    .rst_n        (rst_n),
    .rec_en       (rec_en && decode_enable),
    .datain       (datain),
    .rec_pkt_done (rec_pkt_done),
    .cmd          (cmd),
    .wdata_push   (wdata_push)
  );

  udp_cmd_ctrl u_ctrl (
    .gmii_rx_clk   (gmii_rx_clk),
    .rst_n         (rst_n),
    .rec_pkt_done  (rec_pkt_done),
    .cmd           (cmd),
    .wr_addr_valid (wr_addr_valid),
    .wr_addr_ready (wr_addr_ready),
    .wr_data_valid (wr_data_valid),
    .wr_data_ready (wr_data_ready),
    .rd_addr_valid (rd_addr_valid),
    .rd_addr_ready (rd_addr_ready),
    .rd_data_ready (rd_data_ready),
    .rd_data_valid (rd_data_valid),
    .tx_start_en   (tx_start_en),
    .tx_req        (tx_req),
    .cnt_load      (cnt_load),
    .cnt_beat      (cnt_beat),
    .cnt_done      (cnt_done),
    .wf_pop        (wf_pop),
    .rf_push       (rf_push),
    .rf_pop        (rf_pop),
    .fifo_flush    (fifo_flush),
    .decode_enable (decode_enable)
  );

  burst_counter u_counter (
    .gmii_rx_clk (gmii_rx_clk),
    .rst_n       (rst_n),
    .load        (cnt_load),
    .len         (cmd.len),
    .beat        (cnt_beat),
    .last        (cnt_last),
    .done        (cnt_done)
  );

  word_fifo #(.DEPTH(udp_cmd_pkg::FIFO_DEPTH)) wr_fifo (
    .gmii_rx_clk (gmii_rx_clk),
    .rst_n       (rst_n),
    .flush       (fifo_flush),
    .push        (wdata_push),
    .din         (datain),
    .pop         (wf_pop),
    .dout        (wr_data),
    .empty       (),
    .full        ()
  );

  word_fifo #(.DEPTH(udp_cmd_pkg::FIFO_DEPTH)) rd_fifo (
    .gmii_rx_clk (gmii_rx_clk),
    .rst_n       (rst_n),
    .flush       (fifo_flush),
    .push        (rf_push),
    .din         (rd_data),
    .pop         (rf_pop),
    .dout        (udp_tx_data),
    .empty       (),
    .full        ()
  );

  // Slave's last flag agrees with our own beat count
  a_rd_last_match: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
    (rd_data_valid && rd_data_ready) |-> (rd_data_last == cnt_last));

endmodule

/* hdl/udp_cmd_ctrl.sv */
`timescale 1ns/1ps

module udp_cmd_ctrl (
  input  logic              gmii_rx_clk,
  input  logic              rst_n,
  input  logic              rec_pkt_done,
  input  udp_cmd_pkg::cmd_t cmd,
  output logic              wr_addr_valid,
  input  logic              wr_addr_ready,
  output logic              wr_data_valid,
  input  logic              wr_data_ready,
  output logic              rd_addr_valid,
  input  logic              rd_addr_ready,
  output logic              rd_data_ready,
  input  logic              rd_data_valid,
  output logic              tx_start_en,
  input  logic              tx_req,
  output logic              cnt_load,
  output logic              cnt_beat,
  input  logic              cnt_done,
  output logic              wf_pop,
  output logic              rf_push,
  output logic              rf_pop,
  output logic              fifo_flush,
  output logic              decode_enable
);

  udp_cmd_pkg::ctrl_state_e state;
  udp_cmd_pkg::ctrl_state_e state_nxt;

  logic wr_ok;
  logic rd_ok;
  logic accept;

  // Write must carry exactly len+1 payload words
  assign wr_ok  = (cmd.op == udp_cmd_pkg::OP_WRITE) &&
                  (cmd.data_cnt == {1'b0, cmd.len} + 9'd1);
  assign rd_ok  = (cmd.op == udp_cmd_pkg::OP_READ);
  assign accept = (state == udp_cmd_pkg::IDLE) && rec_pkt_done;

  always_comb begin
    state_nxt = state;
    case (state)
      udp_cmd_pkg::IDLE: begin
        if (rec_pkt_done) begin
          if (wr_ok) begin
            state_nxt = udp_cmd_pkg::WR_ADDR;
          end else if (rd_ok) begin
            state_nxt = udp_cmd_pkg::RD_ADDR;
          end else begin
            state_nxt = udp_cmd_pkg::DROP;
          end
        end
      end
      udp_cmd_pkg::WR_ADDR:  if (wr_addr_ready) state_nxt = udp_cmd_pkg::WR_DATA;
      udp_cmd_pkg::WR_DATA:  if (cnt_done) state_nxt = udp_cmd_pkg::IDLE;
      udp_cmd_pkg::RD_ADDR:  if (rd_addr_ready) state_nxt = udp_cmd_pkg::RD_DATA;
      udp_cmd_pkg::RD_DATA:  if (cnt_done) state_nxt = udp_cmd_pkg::TX_START;
      udp_cmd_pkg::TX_START: state_nxt = udp_cmd_pkg::TX_SEND;
      udp_cmd_pkg::TX_SEND:  if (cnt_done) state_nxt = udp_cmd_pkg::IDLE;
      default:               state_nxt = udp_cmd_pkg::IDLE;  // DROP lasts one cycle
    endcase
  end

  always_ff @(posedge gmii_rx_clk) begin
    if (!rst_n) begin
      state <= udp_cmd_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign wr_addr_valid = (state == udp_cmd_pkg::WR_ADDR);
  assign wr_data_valid = (state == udp_cmd_pkg::WR_DATA);
  assign rd_addr_valid = (state == udp_cmd_pkg::RD_ADDR);
  assign rd_data_ready = (state == udp_cmd_pkg::RD_DATA);
  assign tx_start_en   = (state == udp_cmd_pkg::TX_START);
  assign decode_enable = (state == udp_cmd_pkg::IDLE);

  // Stray payload of a read packet is cleared too
  assign fifo_flush = (state == udp_cmd_pkg::DROP) || (state == udp_cmd_pkg::RD_ADDR);

  assign cnt_load = (accept && (wr_ok || rd_ok)) || (state == udp_cmd_pkg::TX_START);

  always_comb begin
    case (state)
      udp_cmd_pkg::WR_DATA: cnt_beat = wr_data_ready;
      udp_cmd_pkg::RD_DATA: cnt_beat = rd_data_valid;
      udp_cmd_pkg::TX_SEND: cnt_beat = tx_req;
      default:              cnt_beat = 1'b0;
    endcase
  end

  // First word is popped early so beat 0 sits on wr_data
  assign wf_pop  = (accept && wr_ok) ||
                   ((state == udp_cmd_pkg::WR_DATA) && wr_data_ready && !cnt_done);
  assign rf_push = (state == udp_cmd_pkg::RD_DATA) && rd_data_valid;
  assign rf_pop  = (state == udp_cmd_pkg::TX_SEND) && tx_req;

  // Reply words are requested only after tx_start_en
  a_tx_req_in_send: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
    tx_req |-> (state == udp_cmd_pkg::TX_SEND));

endmodule

/* hdl/burst_counter.sv */
`timescale 1ns/1ps

module burst_counter (
  input  logic              gmii_rx_clk,
  input  logic              rst_n,
  input  logic              load,
  input  udp_cmd_pkg::len_t len,
  input  logic              beat,
  output logic              last,
  output logic              done
);

  udp_cmd_pkg::len_t remaining;
  logic              armed;

  assign last = armed && (remaining == '0);
  assign done = beat && last;

  always_ff @(posedge gmii_rx_clk) begin
    if (!rst_n) begin
      armed     <= 1'b0;
      remaining <= '0;
    end else if (load) begin
      armed     <= 1'b1;
      remaining <= len;
    end else if (beat) begin
      if (remaining == '0) begin
        armed <= 1'b0;  // Burst finished
      end else begin
        remaining <= remaining - 1'b1;
      end
    end
  end

  // Every counted transfer belongs to a burst that was loaded before it
  a_beat_after_load: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
    beat |-> armed);

endmodule

/* hdl/cmd_header_decode.sv */
`timescale 1ns/1ps

module cmd_header_decode (
  input  logic               gmii_rx_clk,
  input  logic               rst_n,
  input  logic               rec_en,
  input  udp_cmd_pkg::word_t datain,
  input  logic               rec_pkt_done,
  output udp_cmd_pkg::cmd_t  cmd,
  output logic               wdata_push
);

  logic [1:0] word_idx;  // 0 header, 1 address, 2 payload
  logic       in_payload;

  assign in_payload = (word_idx == 2'd2);

  // FIFO only takes a full burst, extra words are just counted
  assign wdata_push = rec_en && in_payload &&
                      (cmd.data_cnt < udp_cmd_pkg::wcnt_t'(udp_cmd_pkg::FIFO_DEPTH));

  always_ff @(posedge gmii_rx_clk) begin
    if (!rst_n) begin
      word_idx <= '0;
    end else if (rec_pkt_done) begin
      word_idx <= '0;
    end else if (rec_en && !in_payload) begin
      word_idx <= word_idx + 2'd1;
    end
  end

  always_ff @(posedge gmii_rx_clk) begin
    if (!rst_n) begin
      cmd <= '0;
    end else if (rec_en) begin
      case (word_idx)
        2'd0: begin
          cmd.op       <= datain[31:28];
          cmd.len      <= datain[7:0];
          cmd.data_cnt <= '0;
        end
        2'd1: begin
          cmd.addr <= datain[27:0];
        end
        default: begin
          if (cmd.data_cnt != '1) begin
            cmd.data_cnt <= cmd.data_cnt + 1'b1;  // Saturates
          end
        end
      endcase
    end
  end

  a_done_after_words: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
    !(rec_en && rec_pkt_done));

endmodule

/* hdl/word_fifo.sv */
`timescale 1ns/1ps

module word_fifo #(
  parameter int DEPTH = 16
) (
  input  logic               gmii_rx_clk,
  input  logic               rst_n,
  input  logic               flush,
  input  logic               push,
  input  udp_cmd_pkg::word_t din,
  input  logic               pop,
  output udp_cmd_pkg::word_t dout,
  output logic               empty,
  output logic               full
);

  udp_cmd_pkg::word_t mem [DEPTH];

  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic [$clog2(DEPTH):0]   count;

  assign empty = (count == '0);
  assign full  = (int'(count) == DEPTH);

  always_ff @(posedge gmii_rx_clk) begin
    if (!rst_n || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge gmii_rx_clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge gmii_rx_clk) begin
    if (pop) begin
      dout <= mem[rd_ptr];  // Word shows the cycle after pop
    end
  end

  a_no_overflow: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
    push |-> !full);

  a_no_underflow: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
    pop |-> !empty);

endmodule

/* hdl/udp_cmd_pkg.sv */
package udp_cmd_pkg;

  typedef logic [31:0] word_t;
  typedef logic [27:0] addr_t;
  typedef logic [7:0]  len_t;      // Burst length minus one
  typedef logic [3:0]  opcode_t;
  typedef logic [8:0]  wcnt_t;     // Payload word count, up to 256 and beyond
  typedef logic [3:0]  strb_t;

  localparam opcode_t OP_WRITE = 4'd1;
  localparam opcode_t OP_READ  = 4'd2;

  localparam int FIFO_DEPTH = 256;  // One maximum burst
  localparam int ADDR_STEP  = 4;    // Bytes per beat

  typedef enum logic [2:0] {
    IDLE,
    WR_ADDR,
    WR_DATA,
    RD_ADDR,
    RD_DATA,
    TX_START,
    TX_SEND,
    DROP
  } ctrl_state_e;

  typedef struct packed {
    opcode_t op;
    len_t    len;
    addr_t   addr;
    wcnt_t   data_cnt;
  } cmd_t;

  typedef struct packed {
    addr_t addr;
    len_t  len;
  } bus_req_t;

endpackage
